//--- dtlb.f
hw/tlb_geom_pkg.sv
hw/tlb_entry_pkg.sv
hw/dtlb_ram.sv
hw/dtlb_way.sv
hw/dtlb_plru.sv
hw/lookup_queue.sv
hw/dtlb.sv
tests/dtlb_chk.sv
tests/dtlb_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the DTLB testbench with Verilator.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dtlb_tb -f dtlb.f -o dtlb_sim \
  || { echo "Build error"; exit 1; }
status=0
./obj_dir/dtlb_sim > sim.log 2>&1 || status=1
cat sim.log
grep -q "Verification failed" sim.log && status=1
grep -q "Verification passed" sim.log || status=1
exit $status

//--- tests/dtlb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb_tb;
  import tlb_geom_pkg::*;
  import tlb_entry_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_OPS = 400;
  localparam int RAND_CYCLES = 360;
  localparam int POOL = 12;

  logic clk;
  logic rst;
  logic req_valid;
  logic [VPN_WIDTH-1:0] req_vpn;
  logic req_credit;
  logic resp_valid;
  logic resp_hit;
  logic [PPN_WIDTH-1:0] resp_ppn;
  logic [PERM_WIDTH-1:0] resp_perm;
  logic refill_valid;
  logic [VPN_WIDTH-1:0] refill_vpn;
  logic [PPN_WIDTH-1:0] refill_ppn;
  logic [PERM_WIDTH-1:0] refill_perm;
  logic refill_ready;

  integer seed;
  int credits;
  int errors;
  int checks;
  int req_count;
  int resp_count;
  int hit_count;
  int sweep_cycles;   // Cycles of the reset sweep seen so far.
  logic refill_taken;   // Refill accepted in the cycle just ended.
  logic credit_seen;
  logic [VPN_WIDTH-1:0] pool [POOL];
  logic [VPN_WIDTH-1:0] pending [$];

  // Reference TLB contents.
  logic m_valid [SETS][WAYS];
  logic [VPN_WIDTH-1:0] m_vpn [SETS][WAYS];
  logic [PPN_WIDTH-1:0] m_ppn [SETS][WAYS];
  logic [PERM_WIDTH-1:0] m_perm [SETS][WAYS];
  logic [2:0] m_tree [SETS];   // Root, lower pair, upper pair.

  dtlb dut0 (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_vpn(req_vpn),
    .req_credit(req_credit),
    .resp_valid(resp_valid),
    .resp_hit(resp_hit),
    .resp_ppn(resp_ppn),
    .resp_perm(resp_perm),
    .refill_valid(refill_valid),
    .refill_vpn(refill_vpn),
    .refill_ppn(refill_ppn),
    .refill_perm(refill_perm),
    .refill_ready(refill_ready)
  );

  bind dtlb dtlb_chk chk0 (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_credit(req_credit),
    .resp_valid(resp_valid),
    .refill_ready(refill_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [SET_BITS-1:0] pool_set(input int i);
    if (i < 5)
      return SET_BITS'(3);   // Five VPNs here, so this set evicts.
    if (i < 9)
      return SET_BITS'(17);
    return SET_BITS'(30);
  endfunction

  function automatic int find_way(input logic [VPN_WIDTH-1:0] vpn);
    int set_idx;
    set_idx = int'(vpn[SET_BITS-1:0]);
    for (int w = 0; w < WAYS; w++)
    begin
      if (m_valid[set_idx][w] && m_vpn[set_idx][w] == vpn)
        return w;
    end
    return -1;
  endfunction

  function automatic int plru_victim(input int set_idx);
    if (!m_tree[set_idx][0])
      return m_tree[set_idx][1] ? 1 : 0;
    return m_tree[set_idx][2] ? 3 : 2;
  endfunction

  task automatic plru_touch(input int set_idx, input int way);
    if (way < 2)
    begin
      m_tree[set_idx][0] = 1'b1;
      m_tree[set_idx][1] = (way == 0);
    end
    else
    begin
      m_tree[set_idx][0] = 1'b0;
      m_tree[set_idx][2] = (way == 2);
    end
  endtask

  task automatic model_refill(input logic [VPN_WIDTH-1:0] vpn,
                              input logic [PPN_WIDTH-1:0] ppn,
                              input logic [PERM_WIDTH-1:0] perm);
    int set_idx;
    int way;
    set_idx = int'(vpn[SET_BITS-1:0]);
    way = find_way(vpn);
    if (way < 0)
    begin
      way = plru_victim(set_idx);
      for (int w = WAYS - 1; w >= 0; w--)
      begin
        if (!m_valid[set_idx][w])
          way = w;
      end
    end
    m_valid[set_idx][way] = 1'b1;
    m_vpn[set_idx][way] = vpn;
    m_ppn[set_idx][way] = ppn;
    m_perm[set_idx][way] = perm;
    plru_touch(set_idx, way);
  endtask

  task automatic check_response();
    logic [VPN_WIDTH-1:0] vpn;
    int set_idx;
    int way;
    logic [PPN_WIDTH-1:0] exp_ppn;
    logic [PERM_WIDTH-1:0] exp_perm;
    resp_count++;
    if (pending.size() == 0)
    begin
      errors++;
      $display("Response at %0t with no request outstanding", $time);
      return;
    end
    vpn = pending.pop_front();
    set_idx = int'(vpn[SET_BITS-1:0]);
    way = find_way(vpn);
    exp_ppn = '0;
    exp_perm = '0;
    if (way >= 0)
    begin
      exp_ppn = m_ppn[set_idx][way];
      exp_perm = m_perm[set_idx][way];
      plru_touch(set_idx, way);
    end
    if (resp_hit)
      hit_count++;
    check_value("resp_hit", 64'(resp_hit), 64'(way >= 0));
    check_value("resp_ppn", 64'(resp_ppn), 64'(exp_ppn));
    check_value("resp_perm", 64'(resp_perm), 64'(exp_perm));
  endtask

  // Outputs are sampled mid-cycle, after the inputs have settled.
  always @(negedge clk)
  begin
    if (rst)
    begin
      refill_taken = 1'b0;
      credit_seen = 1'b0;
      sweep_cycles = 0;
    end
    else
    begin
      refill_taken = refill_valid && refill_ready;
      check_value("resp_valid", 64'(resp_valid), 64'(credit_seen));
      check_value("refill_ready", 64'(refill_ready),
                  64'(sweep_cycles >= SETS && !credit_seen));
      if (sweep_cycles < SETS)
        sweep_cycles++;
      if (resp_valid)
        check_response();
      if (refill_taken)
        model_refill(refill_vpn, refill_ppn, refill_perm);
      credit_seen = req_credit;
      if (req_credit)
        credits++;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic push_request(input logic [VPN_WIDTH-1:0] vpn);
    req_valid = 1'b1;
    req_vpn = vpn;
    credits--;
    req_count++;
    pending.push_back(vpn);
  endtask

  task automatic send_lookup(input logic [VPN_WIDTH-1:0] vpn);
    while (credits == 0)
      next_cycle();
    push_request(vpn);
    next_cycle();
  endtask

  task automatic send_refill(input logic [VPN_WIDTH-1:0] vpn,
                             input logic [PPN_WIDTH-1:0] ppn,
                             input logic [PERM_WIDTH-1:0] perm);
    refill_valid = 1'b1;
    refill_vpn = vpn;
    refill_ppn = ppn;
    refill_perm = perm;
    next_cycle();
    while (!refill_taken)
      next_cycle();
    refill_valid = 1'b0;
  endtask

  task automatic drain();
    while (pending.size() != 0)
      next_cycle();
    check_value("credits", 64'(credits), 64'(QUEUE_DEPTH));
    check_value("resp_count", 64'(resp_count), 64'(req_count));
  endtask

  initial
  begin
    #(NUM_OPS * 20 * CLK_PERIOD);
    $display("Timeout with %0d responses outstanding", pending.size());
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    logic [TAG_WIDTH-1:0] tag;
    int hits_before;
    seed = 32'h8781;
    rst = 1'b1;
    clk = 1'b0;
    req_valid = 1'b0;
    req_vpn = '0;
    refill_valid = 1'b0;
    refill_vpn = '0;
    refill_ppn = '0;
    refill_perm = '0;
    credits = QUEUE_DEPTH;
    errors = 0;
    checks = 0;
    req_count = 0;
    resp_count = 0;
    hit_count = 0;
    for (int s = 0; s < SETS; s++)
    begin
      m_tree[s] = '0;
      for (int w = 0; w < WAYS; w++)
        m_valid[s][w] = 1'b0;
    end
    for (int i = 0; i < POOL; i++)
    begin
      tag = TAG_WIDTH'({$random(seed)});
      tag[3:0] = 4'(i);   // Keeps the tags distinct.
      pool[i] = {tag, pool_set(i)};
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Empty TLB.
    for (int i = 0; i < POOL; i++)
      send_lookup(pool[i]);
    drain();
    check_value("hit_count", 64'(hit_count), 64'(0));

    send_refill(pool[0], 28'h00a1000, 2'b10);
    hits_before = hit_count;
    send_lookup(pool[0]);
    send_lookup(pool[1]);
    drain();
    check_value("hit_count", 64'(hit_count - hits_before), 64'(1));

    // Fill the set, move the tree with two hits, then evict.
    send_refill(pool[1], 28'h00a1001, 2'b01);
    send_refill(pool[2], 28'h00a1002, 2'b11);
    send_refill(pool[3], 28'h00a1003, 2'b00);
    send_lookup(pool[0]);
    send_lookup(pool[2]);
    drain();
    send_refill(pool[4], 28'h00a1004, 2'b10);
    hits_before = hit_count;
    for (int i = 0; i < 5; i++)
      send_lookup(pool[i]);
    drain();
    check_value("set_hits", 64'(hit_count - hits_before), 64'(WAYS));

    // Resident VPN is rewritten in place.
    send_refill(pool[4], 28'h0b00004, 2'b01);
    hits_before = hit_count;
    for (int i = 0; i < 5; i++)
      send_lookup(pool[i]);
    drain();
    check_value("set_hits", 64'(hit_count - hits_before), 64'(WAYS));

    for (int c = 0; c < RAND_CYCLES; c++)
    begin
      if (refill_valid && refill_taken)
        refill_valid = 1'b0;
      if (!refill_valid && ({$random(seed)} % 6) == 0)
      begin
        refill_valid = 1'b1;
        refill_vpn = pool[{$random(seed)} % POOL];
        refill_ppn = PPN_WIDTH'($random(seed));
        refill_perm = PERM_WIDTH'($random(seed));
      end
      if (credits > 0 && ({$random(seed)} % 2) == 0)
        push_request(pool[{$random(seed)} % POOL]);
      next_cycle();
    end
    while (refill_valid && !refill_taken)
      next_cycle();
    refill_valid = 1'b0;
    drain();

    $display("Checks %0d, errors %0d, requests %0d, responses %0d",
             checks, errors, req_count, resp_count);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/dtlb_chk.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb_chk (
  input logic clk,
  input logic rst,
  input logic req_valid,
  input logic req_credit,
  input logic resp_valid,
  input logic refill_ready
);
  import tlb_geom_pkg::*;

  int in_flight;   // Requests queued and not yet credited back.

  always_ff @(posedge clk)
  begin
    if (rst)
      in_flight <= 0;
    else
      in_flight <= in_flight + int'(req_valid) - int'(req_credit);
  end

  a_credit_spent: assert property (@(posedge clk) disable iff (rst)
    req_credit |-> in_flight > 0)
    else $error("credit returned with no request queued");

  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    in_flight <= QUEUE_DEPTH)
    else $error("more requests queued than queue entries");

  a_resp_after_deq: assert property (@(posedge clk) disable iff (rst)
    resp_valid |-> $past(req_credit))
    else $error("response without a dequeue in the previous cycle");

  a_refill_blocked: assert property (@(posedge clk) disable iff (rst)
    $past(req_credit) |-> !refill_ready)
    else $error("refill_ready high while stage 1 holds a lookup");

endmodule

`default_nettype wire

//--- hw/dtlb.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 req_valid,
  input  logic [tlb_geom_pkg::VPN_WIDTH-1:0]   req_vpn,
  output logic                                 req_credit,
  output logic                                 resp_valid,
  output logic                                 resp_hit,
  output logic [tlb_entry_pkg::PPN_WIDTH-1:0]  resp_ppn,
  output logic [tlb_entry_pkg::PERM_WIDTH-1:0] resp_perm,
  input  logic                                 refill_valid,
  input  logic [tlb_geom_pkg::VPN_WIDTH-1:0]   refill_vpn,
  input  logic [tlb_entry_pkg::PPN_WIDTH-1:0]  refill_ppn,
  input  logic [tlb_entry_pkg::PERM_WIDTH-1:0] refill_perm,
  output logic                                 refill_ready
);
  import tlb_geom_pkg::*;
  import tlb_entry_pkg::*;

  logic deq;
  logic q_empty;
  logic [VPN_WIDTH-1:0] head_vpn;
  logic refill_fire;
  logic rd_en;
  logic [VPN_WIDTH-1:0] rd_vpn;
  logic s1_lookup;
  logic s1_refill;
  logic [VPN_WIDTH-1:0] s1_vpn;
  logic [PPN_WIDTH-1:0] s1_ppn;
  logic [PERM_WIDTH-1:0] s1_perm;
  logic sweep_busy;
  logic [SET_BITS-1:0] sweep_set;
  logic [WAYS-1:0] hit_vec;
  logic [WAYS-1:0] valid_vec;
  logic [WAYS-1:0] wr_en_vec;
  logic [ENTRY_WIDTH-1:0] way_entry [WAYS];
  logic [ENTRY_WIDTH-1:0] hit_entry;
  logic [WAY_BITS-1:0] hit_way;
  logic [WAY_BITS-1:0] victim;
  logic [WAY_BITS-1:0] fill_way;
  logic touch;
  logic [WAY_BITS-1:0] touch_way;

  // A pending refill holds off the queue.
  assign deq = !q_empty && !refill_valid && !sweep_busy;
  assign refill_ready = !s1_lookup && !sweep_busy;
  assign refill_fire = refill_valid && refill_ready;

  // Stage 0 reads the set for a lookup or for a refill.
  assign rd_en = deq || refill_fire;
  assign rd_vpn = deq ? head_vpn : refill_vpn;

  lookup_queue queue0 (
    .clk(clk),
    .rst(rst),
    .push(req_valid),
    .push_vpn(req_vpn),
    .deq(deq),
    .head_vpn(head_vpn),
    .empty(q_empty),
    .credit(req_credit)
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      s1_lookup <= 1'b0;
      s1_refill <= 1'b0;
    end
    else
    begin
      s1_lookup <= deq;
      s1_refill <= refill_fire;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_en)
      s1_vpn <= rd_vpn;
    if (refill_fire)
    begin
      s1_ppn <= refill_ppn;
      s1_perm <= refill_perm;
    end
  end

  // Clears one set per cycle after reset.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sweep_busy <= 1'b1;
      sweep_set <= '0;
    end
    else if (sweep_busy)
    begin
      sweep_set <= sweep_set + 1'b1;
      if (int'(sweep_set) == SETS - 1)
        sweep_busy <= 1'b0;
    end
  end

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    assign wr_en_vec[w] = s1_refill && (fill_way == WAY_BITS'(w));

    dtlb_way way (
      .clk(clk),
      .rst(rst),
      .rd_en(rd_en),
      .rd_vpn(rd_vpn),
      .hit(hit_vec[w]),
      .valid(valid_vec[w]),
      .rd_entry(way_entry[w]),
      .wr_en(wr_en_vec[w]),
      .wr_vpn(s1_vpn),
      .wr_ppn(s1_ppn),
      .wr_perm(s1_perm),
      .clear(sweep_busy),
      .clear_set(sweep_set)
    );
  end

  // At most one way hits, so OR-ing the masked entries selects it.
  always_comb
  begin
    hit_entry = '0;
    hit_way = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (hit_vec[w])
      begin
        hit_entry = hit_entry | way_entry[w];
        hit_way = hit_way | WAY_BITS'(w);
      end
    end
  end

  assign resp_valid = s1_lookup;
  assign resp_hit = |hit_vec;
  assign resp_ppn = hit_entry[PPN_HI:PPN_LO];   // Zero on a miss.
  assign resp_perm = hit_entry[PERM_HI:PERM_LO];

  // Same VPN first, then lowest invalid way, then the tree victim.
  always_comb
  begin
    fill_way = victim;
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (!valid_vec[w])
        fill_way = WAY_BITS'(w);
    end
    if (|hit_vec)
      fill_way = hit_way;
  end

  assign touch = s1_refill || (s1_lookup && resp_hit);
  assign touch_way = s1_refill ? fill_way : hit_way;

  dtlb_plru plru0 (
    .clk(clk),
    .rst(rst),
    .set(s1_vpn[SET_BITS-1:0]),
    .touch(touch),
    .touch_way(touch_way),
    .victim(victim)
  );

endmodule

`default_nettype wire

//--- hw/lookup_queue.sv
`timescale 1ns/10ps
`default_nettype none

module lookup_queue (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               push,
  input  logic [tlb_geom_pkg::VPN_WIDTH-1:0] push_vpn,
  input  logic                               deq,
  output logic [tlb_geom_pkg::VPN_WIDTH-1:0] head_vpn,
  output logic                               empty,
  output logic                               credit
);
  import tlb_geom_pkg::*;

  logic [VPN_WIDTH-1:0] slots [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(QUEUE_DEPTH+1)-1:0] count;

  assign head_vpn = slots[rd_ptr];
  assign empty = (count == '0);
  assign credit = deq;   // One credit back per dequeued entry.

  // Requester credits keep this from overflowing.
  always_ff @(posedge clk)
  begin
    if (push)
      slots[wr_ptr] <= push_vpn;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (int'(wr_ptr) == QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (deq)
        rd_ptr <= (int'(rd_ptr) == QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({push, deq})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dtlb_plru.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb_plru (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [tlb_geom_pkg::SET_BITS-1:0] set,
  input  logic                              touch,
  input  logic [tlb_geom_pkg::WAY_BITS-1:0] touch_way,
  output logic [tlb_geom_pkg::WAY_BITS-1:0] victim
);
  import tlb_geom_pkg::*;

  // Bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3.
  logic [2:0] tree [SETS];
  logic [2:0] cur_bits;
  logic [2:0] new_bits;

  assign cur_bits = tree[set];

  // A zero bit points at the lower half.
  assign victim = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

  // Point every node on the path away from the touched way.
  always_comb
  begin
    new_bits = cur_bits;
    new_bits[0] = ~touch_way[1];
    if (touch_way[1])
      new_bits[2] = ~touch_way[0];
    else
      new_bits[1] = ~touch_way[0];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < SETS; i++)
        tree[i] <= '0;
    end
    else if (touch)
    begin
      tree[set] <= new_bits;
    end
  end

endmodule

`default_nettype wire

//--- hw/dtlb_way.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb_way (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  rd_en,
  input  logic [tlb_geom_pkg::VPN_WIDTH-1:0]    rd_vpn,
  output logic                                  hit,
  output logic                                  valid,
  output logic [tlb_entry_pkg::ENTRY_WIDTH-1:0] rd_entry,
  input  logic                                  wr_en,
  input  logic [tlb_geom_pkg::VPN_WIDTH-1:0]    wr_vpn,
  input  logic [tlb_entry_pkg::PPN_WIDTH-1:0]   wr_ppn,
  input  logic [tlb_entry_pkg::PERM_WIDTH-1:0]  wr_perm,
  input  logic                                  clear,
  input  logic [tlb_geom_pkg::SET_BITS-1:0]     clear_set
);
  import tlb_geom_pkg::*;
  import tlb_entry_pkg::*;

  logic [TAG_WIDTH-1:0] tag_q;
  logic [ENTRY_WIDTH-1:0] ram_rd;
  logic [ENTRY_WIDTH-1:0] fill_entry;
  logic [ENTRY_WIDTH-1:0] ram_wr_data;
  logic [SET_BITS-1:0] ram_wr_addr;

  // Tag is captured in the same cycle as the RAM read address.
  always_ff @(posedge clk)
  begin
    if (rd_en)
      tag_q <= rd_vpn[VPN_WIDTH-1:SET_BITS];
  end

  assign rd_entry = ram_rd;
  assign valid = ram_rd[VALID_BIT];
  assign hit = valid && (ram_rd[TAG_HI:TAG_LO] == tag_q);

  always_comb
  begin
    fill_entry = '0;
    fill_entry[VALID_BIT] = 1'b1;
    fill_entry[TAG_HI:TAG_LO] = wr_vpn[VPN_WIDTH-1:SET_BITS];
    fill_entry[PPN_HI:PPN_LO] = wr_ppn;
    fill_entry[PERM_HI:PERM_LO] = wr_perm;
  end

  assign ram_wr_addr = clear ? clear_set : wr_vpn[SET_BITS-1:0];
  assign ram_wr_data = clear ? '0 : fill_entry;   // Sweep writes invalid entries.

  dtlb_ram ram0 (
    .clk(clk),
    .rst(rst),
    .rd_en(rd_en),
    .rd_addr(rd_vpn[SET_BITS-1:0]),
    .rd_data(ram_rd),
    .wr_en(wr_en || clear),
    .wr_addr(ram_wr_addr),
    .wr_data(ram_wr_data)
  );

endmodule

`default_nettype wire

//--- hw/dtlb_ram.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb_ram (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                rd_en,
  input  logic [tlb_geom_pkg::SET_BITS-1:0]   rd_addr,
  output logic [tlb_entry_pkg::ENTRY_WIDTH-1:0] rd_data,
  input  logic                                wr_en,
  input  logic [tlb_geom_pkg::SET_BITS-1:0]   wr_addr,
  input  logic [tlb_entry_pkg::ENTRY_WIDTH-1:0] wr_data
);
  import tlb_geom_pkg::*;
  import tlb_entry_pkg::*;

  logic [ENTRY_WIDTH-1:0] mem [SETS];
  logic [SET_BITS-1:0] rd_addr_q;

  assign rd_data = mem[rd_addr_q];   // Read after the address register.

  always_ff @(posedge clk)
  begin
    if (rst)
      rd_addr_q <= '0;
    else if (rd_en)
      rd_addr_q <= rd_addr;
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

endmodule

`default_nettype wire

//--- hw/tlb_entry_pkg.sv
`default_nettype none

package tlb_entry_pkg;

  localparam int PPN_WIDTH = 28;
  localparam int PERM_WIDTH = 2;   // Writable and user.

  // Entry layout, from the low end up.
  localparam int PERM_LO = 0;
  localparam int PERM_HI = PERM_LO + PERM_WIDTH - 1;
  localparam int PPN_LO = PERM_HI + 1;
  localparam int PPN_HI = PPN_LO + PPN_WIDTH - 1;
  localparam int TAG_LO = PPN_HI + 1;
  localparam int TAG_HI = TAG_LO + tlb_geom_pkg::TAG_WIDTH - 1;
  localparam int VALID_BIT = TAG_HI + 1;

  localparam int ENTRY_WIDTH = VALID_BIT + 1;   // 62 bits.

endpackage

`default_nettype wire

//--- hw/tlb_geom_pkg.sv
`default_nettype none

package tlb_geom_pkg;

  // Virtual page number, split into tag and set index.
  localparam int VPN_WIDTH = 36;
  localparam int SET_BITS = 5;   // Low VPN bits.
  localparam int SETS = 1 << SET_BITS;
  localparam int TAG_WIDTH = VPN_WIDTH - SET_BITS;

  // Associativity.
  localparam int WAYS = 4;
  localparam int WAY_BITS = 2;

  // Lookup queue size and the requester's starting credit count.
  localparam int QUEUE_DEPTH = 4;

endpackage

`default_nettype wire
